// ==== source/rtc_pkg.sv ====
package rtc_pkg;

  // raw register image, seconds byte at the bottom
  localparam int datetime_bits = 56;
  // 32 nibbles on screen
  localparam int display_bits = 128;

  // MCP7940N control byte for write and read
  localparam logic [7:0] rtc_addr_wr = 8'hDE;
  localparam logic [7:0] rtc_addr_rd = 8'hDF;
  // seconds register, the read pointer auto-increments from here
  localparam logic [7:0] rtc_reg_first = 8'h00;

  // 4x5 glyphs, row r in bits 4*r+3 .. 4*r, bit 3 of a row is the leftmost pixel
  // literal reads bottom row first
  localparam logic [19:0] hex_glyph [16] = '{
    20'h69996, 20'h72262, 20'hF861E, 20'hE161E,
    20'h11F99, 20'hE1E8F, 20'h69E86, 20'h4421F,
    20'h69696, 20'h61796, 20'h99F96, 20'hE9E9E,
    20'h78887, 20'hE999E, 20'hF8E8F, 20'h88E8F
  };

  // rgb565 colours
  localparam logic [15:0] color_fg = 16'hFFFF;
  localparam logic [15:0] color_bg = 16'h0000;

endpackage

// ==== source/i2c_byte_if.sv ====
interface i2c_byte_if;

  // command strobes, one per cycle and only while the engine idles
  logic       cmd_start;
  logic       cmd_stop;
  logic       cmd_write;
  logic       cmd_read;
  logic [7:0] wdata;
  // 0 sends ACK after a read byte
  logic       ack_out;

  // completion pulse and results
  logic       done;
  logic [7:0] rdata;
  // acknowledge seen after a write, 0 is ACK
  logic       ack_in;

  modport poller (
    output cmd_start, cmd_stop, cmd_write, cmd_read, wdata, ack_out,
    input  done, rdata, ack_in
  );

  modport engine (
    input  cmd_start, cmd_stop, cmd_write, cmd_read, wdata, ack_out,
    output done, rdata, ack_in
  );

endinterface

// ==== source/btn_debounce.sv ====
module btn_debounce #(
  parameter int debounce_bits = 16,
  parameter int btns = 3
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic [btns-1:0] btn,
  output logic [btns-1:0] debounced,
  output logic [btns-1:0] rising,
  output logic [btns-1:0] falling
);

  // two-stage synchroniser for the raw pins
  logic [btns-1:0] sync_1;
  logic [btns-1:0] sync_2;
  // top bit set means the input held its new level long enough
  logic [debounce_bits:0] cnt [btns];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_1 <= '0;
      sync_2 <= '0;
    end else begin
      sync_1 <= btn;
      sync_2 <= sync_1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < btns; i++) begin
        cnt[i] <= '0;
      end
      debounced <= '0;
      rising    <= '0;
      falling   <= '0;
    end else begin
      rising  <= '0;
      falling <= '0;
      for (int i = 0; i < btns; i++) begin
        if (sync_2[i] == debounced[i]) begin
          // a bounce back to the old level restarts the count
          cnt[i] <= '0;
        end else if (cnt[i][debounce_bits]) begin
          // stable long enough, take the new level and flag the edge
          debounced[i] <= sync_2[i];
          rising[i]    <= sync_2[i];
          falling[i]   <= ~sync_2[i];
          cnt[i]       <= '0;
        end else begin
          cnt[i] <= cnt[i] + 1'b1;
        end
      end
    end
  end

endmodule

// ==== source/i2c_byte_engine.sv ====
module i2c_byte_engine #(
  parameter int i2c_div = 63
) (
  input  logic       clk,
  input  logic       rst_n,
  i2c_byte_if.engine bus,
  input  logic       sda_in,
  output logic       scl_oe,
  output logic       sda_oe
);

  localparam int div_w = $clog2(i2c_div + 1);

  typedef enum logic [1:0] {e_idle, e_start, e_stop, e_byte} e_state_t;

  e_state_t         state;
  logic [div_w-1:0] div_cnt;
  logic             qtick;
  // quarter of the current SCL period
  logic [1:0]       quarter;
  // 0..7 data bits, 8 is the acknowledge slot
  logic [3:0]       bit_cnt;
  logic [7:0]       shreg;
  logic             is_read;
  logic             ack_bit;
  logic             sda_meta;
  logic             sda_s;
  logic             next_oe;

  assign qtick = (div_cnt == div_w'(i2c_div - 1));

  // SDA pull for the bit that follows the current one
  // in the ack slot we release on write and drive our ACK on read
  assign next_oe = (bit_cnt == 4'd7) ? (is_read & ~ack_bit) : (~is_read & ~shreg[7]);

  // sda comes from the pad, resync it
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sda_meta <= 1'b1;
      sda_s    <= 1'b1;
    end else begin
      sda_meta <= sda_in;
      sda_s    <= sda_meta;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= e_idle;
      div_cnt    <= '0;
      quarter    <= '0;
      bit_cnt    <= '0;
      is_read    <= 1'b0;
      ack_bit    <= 1'b1;
      scl_oe     <= 1'b0;
      sda_oe     <= 1'b0;
      bus.done   <= 1'b0;
      bus.rdata  <= '0;
      bus.ack_in <= 1'b1;
    end else begin
      bus.done <= 1'b0;
      if (state == e_idle) begin
        div_cnt <= '0;
        quarter <= '0;
        bit_cnt <= '0;
        // first quarter action happens right at accept
        if (bus.cmd_start) begin
          state  <= e_start;
          sda_oe <= 1'b0;
        end else if (bus.cmd_stop) begin
          state  <= e_stop;
          sda_oe <= 1'b1;
        end else if (bus.cmd_write) begin
          state   <= e_byte;
          is_read <= 1'b0;
          sda_oe  <= ~bus.wdata[7];
        end else if (bus.cmd_read) begin
          state   <= e_byte;
          is_read <= 1'b1;
          ack_bit <= bus.ack_out;
          sda_oe  <= 1'b0;
        end
      end else if (!qtick) begin
        div_cnt <= div_cnt + 1'b1;
      end else begin
        div_cnt <= '0;
        quarter <= quarter + 1'b1;
        case (quarter)
          // SCL goes high in the second quarter for every operation
          2'd0: scl_oe <= 1'b0;
          2'd1: begin
            // SDA edges while SCL is high make start and stop
            if (state == e_start) begin
              sda_oe <= 1'b1;
            end else if (state == e_stop) begin
              sda_oe <= 1'b0;
            end else if (bit_cnt == 4'd8 && !is_read) begin
              bus.ack_in <= sda_s;
            end
          end
          // pull SCL low again, a stop leaves the bus released
          2'd2: begin
            if (state != e_stop) begin
              scl_oe <= 1'b1;
            end
          end
          default: begin
            if (state == e_byte && bit_cnt != 4'd8) begin
              bit_cnt <= bit_cnt + 1'b1;
              sda_oe  <= next_oe;
            end else begin
              state    <= e_idle;
              bus.done <= 1'b1;
              if (is_read) begin
                bus.rdata <= shreg;
              end
            end
          end
        endcase
      end
    end
  end

  // shift register serves both directions
  // on write the sampled line just echoes our own bit
  always_ff @(posedge clk) begin
    if (state == e_idle && bus.cmd_write) begin
      shreg <= bus.wdata;
    end else if (state == e_byte && qtick && quarter == 2'd1 && bit_cnt != 4'd8) begin
      shreg <= {shreg[6:0], sda_s};
    end
  end

endmodule

// ==== source/rtc_poller.sv ====
module rtc_poller import rtc_pkg::*; #(
  parameter int slow_bits = 18
) (
  input  logic                     clk,
  input  logic                     rst_n,
  i2c_byte_if.poller               bus,
  output logic                     tick,
  output logic [datetime_bits-1:0] datetime
);

  typedef enum logic [1:0] {p_idle, p_issue, p_wait} p_state_t;

  // steps 0 start, 1..2 writes, 3 repeated start, 4 write, 5..11 reads, 12 stop
  localparam logic [3:0] step_rd_last = 4'd11;
  localparam logic [3:0] step_stop    = 4'd12;

  p_state_t                 state;
  logic [slow_bits-1:0]     slow_cnt;
  logic [3:0]               step;
  logic                     aborted;
  logic [datetime_bits-1:0] rx_shift;
  logic                     step_start;
  logic                     step_write;
  logic                     step_read;
  logic                     issue;

  assign step_start = (step == 4'd0) || (step == 4'd3);
  assign step_write = (step == 4'd1) || (step == 4'd2) || (step == 4'd4);
  assign step_read  = (step >= 4'd5) && (step <= step_rd_last);
  assign issue      = (state == p_issue);

  // strobes last only the single issue cycle
  assign bus.cmd_start = issue && step_start;
  assign bus.cmd_write = issue && step_write;
  assign bus.cmd_read  = issue && step_read;
  assign bus.cmd_stop  = issue && (step == step_stop);
  assign bus.wdata     = (step == 4'd1) ? rtc_addr_wr :
                         (step == 4'd4) ? rtc_addr_rd : rtc_reg_first;
  // NACK only on the last byte
  assign bus.ack_out   = (step == step_rd_last);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= p_idle;
      slow_cnt <= '0;
      step     <= '0;
      aborted  <= 1'b0;
      tick     <= 1'b0;
      datetime <= '0;
    end else begin
      slow_cnt <= slow_cnt + 1'b1;
      tick     <= 1'b0;
      case (state)
        p_idle: begin
          // launch when the interval counter wraps
          if (&slow_cnt) begin
            step    <= '0;
            aborted <= 1'b0;
            state   <= p_issue;
          end
        end
        p_issue: state <= p_wait;
        p_wait: begin
          if (bus.done) begin
            if (step == step_stop) begin
              state <= p_idle;
              if (!aborted) begin
                tick     <= 1'b1;
                datetime <= rx_shift;
              end
            end else if (step_write && bus.ack_in) begin
              // no ACK from the chip, bail out through a stop
              aborted <= 1'b1;
              step    <= step_stop;
              state   <= p_issue;
            end else begin
              step  <= step + 1'b1;
              state <= p_issue;
            end
          end
        end
        default: state <= p_idle;
      endcase
    end
  end

  // bytes enter at the top, after seven reads seconds sits in 7:0
  always_ff @(posedge clk) begin
    if (state == p_wait && bus.done && step_read) begin
      rx_shift <= {bus.rdata, rx_shift[datetime_bits-1:8]};
    end
  end

endmodule

// ==== source/clock_display.sv ====
module clock_display import rtc_pkg::*; (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     tick,
  input  logic [datetime_bits-1:0] datetime,
  input  logic [2:1]               rising,
  output logic [display_bits-1:0]  display,
  output logic [7:0]               led
);

  logic [datetime_bits-1:0] dt_q;
  logic [2:0]               cursor;
  // one byte per cursor position
  logic [63:0]              marker;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dt_q   <= '0;
      cursor <= '0;
    end else begin
      if (tick) begin
        dt_q <= datetime;
      end
      // left on btn 1, right on btn 2, both at once cancel
      case (rising)
        2'b01:   cursor <= cursor - 1'b1;
        2'b10:   cursor <= cursor + 1'b1;
        default: cursor <= cursor;
      endcase
    end
  end

  always_comb begin
    for (int i = 0; i < 8; i++) begin
      marker[i*8 +: 8] = (cursor == 3'(i)) ? 8'h11 : 8'h00;
    end
  end

  // marker on top, then the cursor byte, then the time registers
  assign display = {marker, 5'b0, cursor, dt_q};
  // seconds on the leds
  assign led     = dt_q[7:0];

endmodule

// ==== source/hex_renderer.sv ====
module hex_renderer import rtc_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [display_bits-1:0] display,
  input  logic [6:0]              x,
  input  logic [3:0]              y,
  output logic [15:0]             color
);

  // 16 columns by 2 rows of 8x8 cells
  logic [4:0]  nib_idx;
  logic [3:0]  nibble;
  logic [19:0] glyph;
  logic [4:0]  bit_idx;
  logic        in_glyph;
  logic        pix_on;

  // row r, column c shows nibble 16*r + 15 - c
  assign nib_idx  = {y[3], ~x[6:3]};
  assign nibble   = display[{nib_idx, 2'b00} +: 4];
  assign glyph    = hex_glyph[nibble];

  // glyph occupies the top-left 4x5 of the cell
  assign in_glyph = !x[2] && (y[2:0] < 3'd5);
  // row base 4*yo, leftmost pixel is bit 3 of the row
  assign bit_idx  = {y[2:0], ~x[1:0]};
  assign pix_on   = in_glyph ? glyph[bit_idx] : 1'b0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      color <= color_bg;
    end else begin
      color <= pix_on ? color_fg : color_bg;
    end
  end

endmodule

// ==== source/lcd_pixel_spi.sv ====
module lcd_pixel_spi #(
  parameter int lcd_width = 128,
  parameter int lcd_height = 16
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [15:0]                   color,
  output logic [$clog2(lcd_width)-1:0]  x,
  output logic [$clog2(lcd_height)-1:0] y,
  output logic                          spi_clk,
  output logic                          spi_mosi,
  output logic                          spi_dc,
  output logic                          spi_csn
);

  localparam int x_w = $clog2(lcd_width);
  localparam int y_w = $clog2(lcd_height);

  // 32 cycles per pixel, load at phase 31
  logic [4:0]  phase;
  // low during the prefetch after reset
  logic        started;
  logic [15:0] shreg;
  logic        load;

  assign load     = (phase == 5'd31);
  assign spi_mosi = shreg[15];
  // pixel data only, no commands
  assign spi_dc   = 1'b1;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // start at 28 so the first load comes after 4 cycles
      phase   <= 5'd28;
      started <= 1'b0;
      spi_clk <= 1'b0;
      spi_csn <= 1'b1;
      shreg   <= '0;
      x       <= '0;
      y       <= '0;
    end else begin
      phase <= phase + 1'b1;
      if (load) begin
        started <= 1'b1;
        spi_csn <= 1'b0;
        spi_clk <= 1'b0;
        shreg   <= color;
        // present the next pixel, the renderer has a full pixel time
        if (x == x_w'(lcd_width - 1)) begin
          x <= '0;
          y <= (y == y_w'(lcd_height - 1)) ? '0 : y + 1'b1;
        end else begin
          x <= x + 1'b1;
        end
      end else if (started) begin
        spi_clk <= ~spi_clk;
        // mosi moves on the falling spi_clk edge
        if (spi_clk) begin
          shreg <= {shreg[14:0], 1'b0};
        end
      end
    end
  end

endmodule

// ==== source/rtc_clock_top.sv ====
module rtc_clock_top import rtc_pkg::*; #(
  parameter int debounce_bits = 16,
  parameter int btns = 3,
  parameter int slow_bits = 18,
  parameter int i2c_div = 63,
  parameter int lcd_width = 128,
  parameter int lcd_height = 16
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [btns-1:0]          btn,
  input  logic                     sda_in,
  output logic                     scl_oe,
  output logic                     sda_oe,
  output logic                     tick,
  output logic [datetime_bits-1:0] datetime,
  output logic [7:0]               led,
  output logic                     spi_clk,
  output logic                     spi_mosi,
  output logic                     spi_dc,
  output logic                     spi_csn
);

  logic [btns-1:0]               btn_rise;
  logic [display_bits-1:0]       display;
  logic [$clog2(lcd_width)-1:0]  x;
  logic [$clog2(lcd_height)-1:0] y;
  logic [15:0]                   color;

  i2c_byte_if i2c_bus ();

  // btn 0 is reserved, only the edges of 1 and 2 are used
  btn_debounce #(.debounce_bits(debounce_bits), .btns(btns)) u_btn (
    .clk(clk), .rst_n(rst_n), .btn(btn),
    .debounced(), .rising(btn_rise), .falling()
  );

  i2c_byte_engine #(.i2c_div(i2c_div)) u_i2c (
    .clk(clk), .rst_n(rst_n), .bus(i2c_bus.engine),
    .sda_in(sda_in), .scl_oe(scl_oe), .sda_oe(sda_oe)
  );

  rtc_poller #(.slow_bits(slow_bits)) u_poll (
    .clk(clk), .rst_n(rst_n), .bus(i2c_bus.poller),
    .tick(tick), .datetime(datetime)
  );

  clock_display u_disp (
    .clk(clk), .rst_n(rst_n), .tick(tick), .datetime(datetime),
    .rising(btn_rise[2:1]), .display(display), .led(led)
  );

  hex_renderer u_hex (
    .clk(clk), .rst_n(rst_n), .display(display), .x(x), .y(y), .color(color)
  );

  lcd_pixel_spi #(.lcd_width(lcd_width), .lcd_height(lcd_height)) u_lcd (
    .clk(clk), .rst_n(rst_n), .color(color), .x(x), .y(y),
    .spi_clk(spi_clk), .spi_mosi(spi_mosi), .spi_dc(spi_dc), .spi_csn(spi_csn)
  );

endmodule

// ==== testbench/rtc_slave_model.sv ====
module rtc_slave_model import rtc_pkg::*; (
  input  logic        clk,
  input  logic        scl_oe,
  input  logic        sda_oe,
  input  logic [55:0] regs,
  input  logic        withhold_ack,
  output logic        sda,
  output int          stop_count,
  output int          errors
);

  typedef enum logic [2:0] {s_idle, s_addr, s_reg, s_reg_done, s_read, s_done} t_state_t;

  t_state_t   state;
  // target pulls SDA low while set
  logic       pull;
  logic       scl;
  logic       scl_now;
  logic       sda_now;
  logic       scl_q;
  logic       sda_q;
  // set for the write address after a start from idle
  logic       first;
  logic       acking;
  // acknowledge sent by the controller after a read byte
  logic       mack;
  logic [7:0] rx;
  logic [7:0] tx;
  int         bitn;
  int         nbyte;

  // open-drain lines with pull-ups, SCL is never stretched
  assign scl = ~scl_oe;
  assign sda = ~(sda_oe | pull);

  initial begin
    state      = s_idle;
    pull       = 1'b0;
    scl_q      = 1'b1;
    sda_q      = 1'b1;
    first      = 1'b1;
    acking     = 1'b0;
    bitn       = 0;
    nbyte      = 0;
    stop_count = 0;
    errors     = 0;
  end

  task protocol_error(input string msg);
    errors++;
    $display("[FAIL] %0t i2c target: %s", $time, msg);
  endtask

  // next register byte, bit 7 goes out while SCL is low
  task load_byte();
    tx   = regs[8*nbyte +: 8];
    bitn = 0;
    pull = ~tx[7];
  endtask

  // eighth bit of a received byte is in, check it and decide the ACK
  task take_byte();
    if (state == s_reg) begin
      assert (rx == rtc_reg_first) else protocol_error($sformatf("register %h", rx));
    end else if (first) begin
      assert (rx == rtc_addr_wr) else protocol_error($sformatf("write address %h", rx));
    end else begin
      assert (rx == rtc_addr_rd) else protocol_error($sformatf("read address %h", rx));
    end
    if (state == s_addr && first && withhold_ack) begin
      // SDA stays released so the controller sees a NACK
      state = s_done;
    end else begin
      pull   = 1'b1;
      acking = 1'b1;
    end
  endtask

  task scl_rise();
    if ((state == s_addr || state == s_reg) && bitn < 8) begin
      rx = {rx[6:0], sda_now};
      bitn++;
    end else if (state == s_read && !acking) begin
      bitn++;
    end else if (state == s_read) begin
      // ACK on bytes 0 to 5, NACK on the last one
      assert (sda_now == (nbyte == 6))
        else protocol_error($sformatf("wrong acknowledge after read byte %0d", nbyte));
      mack = sda_now;
    end
  endtask

  task scl_fall();
    if ((state == s_addr || state == s_reg) && !acking) begin
      if (bitn == 8) begin
        take_byte();
      end
    end else if (state == s_addr || state == s_reg) begin
      // acknowledge slot is over
      pull   = 1'b0;
      acking = 1'b0;
      bitn   = 0;
      if (state == s_reg) begin
        state = s_reg_done;
      end else if (first) begin
        state = s_reg;
      end else begin
        state = s_read;
        nbyte = 0;
        load_byte();
      end
    end else if (state == s_read && !acking) begin
      if (bitn < 8) begin
        pull = ~tx[7 - bitn];
      end else begin
        pull   = 1'b0;
        acking = 1'b1;
      end
    end else if (state == s_read) begin
      acking = 1'b0;
      if (mack) begin
        state = s_done;
      end else begin
        nbyte++;
        load_byte();
      end
    end
  endtask

  always @(negedge clk) begin
    scl_now = scl;
    sda_now = sda;
    if (scl_now && scl_q && sda_q && !sda_now) begin
      // a repeated start is legal only after the register pointer
      first = (state != s_reg_done);
      assert (state == s_idle || state == s_reg_done)
        else protocol_error("start in the middle of a transfer");
      state  = s_addr;
      bitn   = 0;
      acking = 1'b0;
      pull   = 1'b0;
    end else if (scl_now && scl_q && !sda_q && sda_now) begin
      assert (state == s_done) else protocol_error("stop before the transfer finished");
      stop_count <= stop_count + 1;
      state = s_idle;
      pull  = 1'b0;
    end else if (scl_now && !scl_q) begin
      scl_rise();
    end else if (!scl_now && scl_q) begin
      scl_fall();
    end
    scl_q = scl_now;
    sda_q = sda_now;
  end

endmodule

// ==== testbench/tb_rtc_clock.sv ====
module tb_rtc_clock import rtc_pkg::*; ();

  localparam int poll_cycles     = 2 ** 13;
  localparam int frame_pixels    = 128 * 16;
  localparam int watchdog_cycles = 4 * poll_cycles + 2 * frame_pixels * 32 + 10;

  logic         clk;
  logic         rst_n;
  logic [2:0]   btn;
  logic         sda_in;
  logic         scl_oe;
  logic         sda_oe;
  logic         tick;
  logic [55:0]  datetime;
  logic [7:0]   led;
  logic         spi_clk;
  logic         spi_mosi;
  logic         spi_dc;
  logic         spi_csn;
  // target side
  logic [55:0]  regs;
  logic         withhold_ack;
  int           stop_count;
  int           proto_errors;
  logic [31:0]  lfsr;
  logic [55:0]  dt_old;
  logic [2:0]   cursor_model;
  logic [127:0] exp_word;
  int           fail_count = 0;
  int           tests_failed = 0;
  int           mark = 0;
  int           stops_before;
  int           n;
  // frame decoder
  logic         spi_clk_q = 1'b0;
  logic [15:0]  pix_bits;
  int           bit_cnt = 0;
  int           pix_count = 0;
  int           cell_errs = 0;
  int           pix_errs = 0;

  rtc_clock_top #(.debounce_bits(3), .slow_bits(13), .i2c_div(4)) DUT (
    .clk(clk), .rst_n(rst_n), .btn(btn), .sda_in(sda_in),
    .scl_oe(scl_oe), .sda_oe(sda_oe), .tick(tick), .datetime(datetime), .led(led),
    .spi_clk(spi_clk), .spi_mosi(spi_mosi), .spi_dc(spi_dc), .spi_csn(spi_csn)
  );

  rtc_slave_model slave (
    .clk(clk), .scl_oe(scl_oe), .sda_oe(sda_oe), .regs(regs),
    .withhold_ack(withhold_ack), .sda(sda_in), .stop_count(stop_count),
    .errors(proto_errors)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hB4BC_D35C) : (s >> 1);
  endfunction

  // one LFSR step per register bit
  task automatic draw_regs(output logic [55:0] v);
    for (int i = 0; i < 56; i++) begin
      v    = {lfsr[0], v[55:1]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // marker byte 11 at the cursor, cursor byte, then the time registers
  function automatic logic [127:0] build_display(input logic [55:0] dt, input logic [2:0] cur);
    logic [127:0] w;
    w = {64'b0, 5'b0, cur, dt};
    w[64 + 8*cur +: 8] = 8'h11;
    return w;
  endfunction

  function automatic logic [15:0] expected_color(input logic [127:0] w, input int px,
                                                 input int py);
    int         idx;
    int         xo;
    int         yo;
    logic [3:0] nib;
    idx = 16 * (py / 8) + 15 - px / 8;
    nib = w[4*idx +: 4];
    xo  = px % 8;
    yo  = py % 8;
    if (xo < 4 && yo < 5 && hex_glyph[nib][4*yo + 3 - xo]) begin
      return color_fg;
    end
    return color_bg;
  endfunction

  function automatic int errors_now();
    return fail_count + proto_errors;
  endfunction

  task automatic report_mismatch(input string msg);
    fail_count++;
    $display("[FAIL] %0t %s", $time, msg);
  endtask

  task automatic end_test(input int num, input string name, input int errs);
    if (errs != 0) begin
      tests_failed++;
    end
    $display("test %0d %s: %s, %0d errors", num, name, (errs == 0) ? "ok" : "bad", errs);
  endtask

  // outputs must hold the old image until tick, two poll intervals at most
  task automatic wait_for_tick(input logic [55:0] hold_dt);
    int cnt;
    cnt = 0;
    while (tick !== 1'b1 && cnt < 2 * poll_cycles) begin
      assert (datetime == hold_dt && led == hold_dt[7:0])
        else report_mismatch($sformatf("datetime %h changed before tick", datetime));
      @(negedge clk);
      cnt++;
    end
    if (tick !== 1'b1) begin
      fail_count++;
      $display("no tick within %0d cycles", cnt);
    end
  endtask

  // at tick, then led one cycle later
  task automatic check_new_time();
    assert (datetime == regs)
      else report_mismatch($sformatf("datetime %h expected %h", datetime, regs));
    @(negedge clk);
    assert (led == regs[7:0])
      else report_mismatch($sformatf("led %h expected %h", led, regs[7:0]));
  endtask

  // bounces shorter than the debounce window, then a clean hold and release
  task automatic press_button(input int idx);
    for (int k = 1; k <= 4; k++) begin
      btn[idx] = 1'b1;
      repeat (k) @(negedge clk);
      btn[idx] = 1'b0;
      repeat (2) @(negedge clk);
    end
    btn[idx] = 1'b1;
    repeat (24) @(negedge clk);
    btn[idx] = 1'b0;
    repeat (2) @(negedge clk);
    btn[idx] = 1'b1;
    repeat (3) @(negedge clk);
    btn[idx] = 1'b0;
    repeat (24) @(negedge clk);
  endtask

  task automatic check_pixel(input int px, input int py);
    logic [15:0] exp;
    exp = expected_color(exp_word, px, py);
    assert (pix_bits == exp) else begin
      pix_errs++;
      // cursor digit cell and the marker row
      if (py >= 8 || px / 8 == 1) begin
        cell_errs++;
      end
      report_mismatch($sformatf("pixel (%0d,%0d) %h expected %h", px, py, pix_bits, exp));
    end
  endtask

  // SPI bits taken on spi_clk rising, frames counted from spi_csn low
  always @(negedge clk) begin
    if (!spi_csn && spi_clk && !spi_clk_q) begin
      assert (spi_dc == 1'b1) else report_mismatch("spi_dc low during pixel data");
      pix_bits = {pix_bits[14:0], spi_mosi};
      bit_cnt++;
      if (bit_cnt == 16) begin
        bit_cnt = 0;
        if (pix_count >= frame_pixels && pix_count < 2 * frame_pixels) begin
          check_pixel(pix_count % 128, (pix_count / 128) % 16);
        end
        pix_count++;
      end
    end
    spi_clk_q = spi_clk;
  end

  initial begin
    #(watchdog_cycles * 10);
    $display("watchdog expired after %0d cycles, the run did not complete", watchdog_cycles);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    btn          = '0;
    rst_n        = 1'b0;
    regs         = '0;
    withhold_ack = 1'b0;
    lfsr         = 32'h87da;
    cursor_model = '0;
    repeat (10) begin
      @(negedge clk);
      assert (!scl_oe && !sda_oe && !tick && led == 8'h00 && spi_csn && !spi_clk)
        else report_mismatch("output not at its reset value during reset");
    end
    rst_n = 1'b1;
    @(negedge clk);
    assert (!scl_oe && !sda_oe && !tick && led == 8'h00 && spi_csn && !spi_clk)
      else report_mismatch("output not at its reset value after reset");
    end_test(1, "reset state", errors_now() - mark);
    mark = errors_now();

    draw_regs(regs);
    wait_for_tick('0);
    check_new_time();
    end_test(2, "register read", errors_now() - mark);
    mark = errors_now();

    // new chip contents between polls
    dt_old = regs;
    draw_regs(regs);
    wait_for_tick(dt_old);
    check_new_time();
    end_test(3, "update on tick", errors_now() - mark);
    mark = errors_now();

    // the next poll sees no ACK on the write address
    withhold_ack = 1'b1;
    stops_before = stop_count;
    n = 0;
    while (stop_count == stops_before && n < 2 * poll_cycles) begin
      assert (!tick && led == regs[7:0]) else report_mismatch("tick or led during abort");
      @(negedge clk);
      n++;
    end
    if (stop_count == stops_before) begin
      fail_count++;
      $display("no stop condition after the missing acknowledge");
    end
    assert (!scl_oe && !sda_oe) else report_mismatch("bus not released after the stop");
    repeat (64) begin
      @(negedge clk);
      assert (!tick && led == regs[7:0]) else report_mismatch("tick or led after abort");
    end
    withhold_ack = 1'b0;
    wait_for_tick(regs);
    check_new_time();
    end_test(4, "missing acknowledge", errors_now() - mark);
    mark = errors_now();

    // three steps right, one left
    repeat (3) begin
      press_button(2);
      cursor_model = cursor_model + 1'b1;
    end
    press_button(1);
    cursor_model = cursor_model - 1'b1;
    exp_word = build_display(regs, cursor_model);
    if (pix_count >= frame_pixels) begin
      fail_count++;
      $display("second frame began before the display settled");
    end
    wait (pix_count >= 2 * frame_pixels);
    end_test(5, "cursor", cell_errs);
    end_test(6, "pixel stream", errors_now() - mark);

    $display("tests run 6, tests failed %0d, checks failed %0d", tests_failed, errors_now());
    if (errors_now() == 0 && tests_failed == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
source/rtc_pkg.sv
source/i2c_byte_if.sv
source/btn_debounce.sv
source/i2c_byte_engine.sv
source/rtc_poller.sv
source/clock_display.sv
source/hex_renderer.sv
source/lcd_pixel_spi.sv
source/rtc_clock_top.sv
testbench/rtc_slave_model.sv
testbench/tb_rtc_clock.sv
